/* include/bp_defines.svh */
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// PC and table geometry
`define BP_PC_W        16                    // Fetch and target PC width
`define BP_INDEX_W     4                     // Low PC bits select the entry
`define BP_DEPTH       16                    // Entries per table
`define BP_TAG_W       12                    // Upper PC bits kept as BTB tag

// APB register map
`define BP_APB_AW      8                     // Byte address width
`define BP_APB_DW      32                    // Data width
`define BP_REG_UPDATES 8'h00                 // Resolved branch count
`define BP_REG_MISPRED 8'h04                 // Direction mispredict count
`define BP_REG_CTRL    8'h08                 // Bit 0 clears both counts

`endif

/* src/bp_pkg.sv */
`default_nettype none
`include "bp_defines.svh"

package bp_pkg;

  typedef logic [1:0] bp_ctr_t;                 // 2-bit saturating direction counter

  localparam bp_ctr_t CTR_STRONG_NT = 2'd0;     // Strong not taken
  localparam bp_ctr_t CTR_WEAK_NT   = 2'd1;     // Weak not taken
  localparam bp_ctr_t CTR_WEAK_T    = 2'd2;     // Weak taken
  localparam bp_ctr_t CTR_STRONG_T  = 2'd3;     // Strong taken

  typedef struct packed {
    logic                 valid;                // Entry holds a taken target
    logic [`BP_TAG_W-1:0] tag;                  // Upper PC bits of the owner
    logic [`BP_PC_W-1:0]  target;               // Taken target address
  } btb_entry_t;

  typedef struct packed {
    logic                taken;                 // Redirect fetch to target
    logic                hit;                   // BTB holds this PC
    logic [`BP_PC_W-1:0] target;                // Zero on a miss
  } bp_predict_t;

  typedef struct packed {
    logic                valid;                 // Branch resolved this cycle
    logic [`BP_PC_W-1:0] pc;                    // PC of the resolved branch
    logic                taken;                 // Actual direction
    logic [`BP_PC_W-1:0] target;                // Actual taken target
  } bp_update_t;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [`BP_APB_AW-1:0] paddr;
    logic [`BP_APB_DW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`BP_APB_DW-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

/* src/entry_array.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bp_defines.svh"

////////////////////////////////////////////////////////////////////////////
// Register array shared by the counter table and the target buffer
////////////////////////////////////////////////////////////////////////////
module entry_array
  import bp_pkg::*;
#(
  parameter type entry_t = bp_ctr_t                // Payload held per entry
) (
  input  logic                   clk,              // Core clock
  input  logic                   reset,            // Sync, active high
  input  logic [`BP_INDEX_W-1:0] rd_index,         // Fetch side index
  output entry_t                 rd_entry,         // Fetch side entry
  input  logic [`BP_INDEX_W-1:0] upd_index,        // Update side index
  output entry_t                 upd_entry,        // Entry before the write
  input  logic                   wr_en,            // Write at upd_index
  input  entry_t                 wr_entry          // New entry value
);

  entry_t entries [`BP_DEPTH];                     // One entry per index

  // Write port, all entries cleared on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `BP_DEPTH; i++) begin
        entries[i] <= '0;                          // Strong NT / invalid
      end
    end else if (wr_en) begin
      entries[upd_index] <= wr_entry;              // Visible next cycle
    end
  end

  // Both reads see the old entry during a write
  assign rd_entry  = entries[rd_index];            // Prediction lookup
  assign upd_entry = entries[upd_index];           // Read-modify-write source

endmodule

`default_nettype wire

/* src/counter_table.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bp_defines.svh"

////////////////////////////////////////////////////////////////////////////
// Branch History Table of 2-bit saturating counters
////////////////////////////////////////////////////////////////////////////
module counter_table
  import bp_pkg::*;
(
  input  logic                clk,                 // Core clock
  input  logic                reset,               // Sync, active high
  input  logic [`BP_PC_W-1:0] fetch_pc,            // PC being fetched
  input  bp_update_t          update,              // Resolved branch
  output logic                predict_taken,       // MSB of fetch counter
  output logic                dir_wrong            // Old counter disagreed
);

  logic [`BP_INDEX_W-1:0] fetch_index;             // Low bits of fetch PC
  logic [`BP_INDEX_W-1:0] upd_index;               // Low bits of update PC
  bp_ctr_t                fetch_ctr;               // Counter at fetch index
  bp_ctr_t                old_ctr;                 // Counter at update index
  bp_ctr_t                next_ctr;                // Counter after the step

  assign fetch_index = fetch_pc[`BP_INDEX_W-1:0];
  assign upd_index   = update.pc[`BP_INDEX_W-1:0];

  entry_array #(
    .entry_t   (bp_ctr_t)
  ) ctr_array_inst (
    .clk       (clk),
    .reset     (reset),
    .rd_index  (fetch_index),
    .rd_entry  (fetch_ctr),
    .upd_index (upd_index),
    .upd_entry (old_ctr),
    .wr_en     (update.valid),                     // Every resolved branch steps
    .wr_entry  (next_ctr)
  );

  assign predict_taken = fetch_ctr[1];             // Weak or strong taken

  // One step toward the actual direction, saturating at both ends
  always_comb begin
    case (old_ctr)
      CTR_STRONG_NT: next_ctr = update.taken ? CTR_WEAK_NT  : CTR_STRONG_NT;
      CTR_WEAK_NT:   next_ctr = update.taken ? CTR_WEAK_T   : CTR_STRONG_NT;
      CTR_WEAK_T:    next_ctr = update.taken ? CTR_STRONG_T : CTR_WEAK_NT;
      default:       next_ctr = update.taken ? CTR_STRONG_T : CTR_WEAK_T;
    endcase
  end

  // Direction the table would have given this branch before the edge
  assign dir_wrong = update.valid && (update.taken != old_ctr[1]);

endmodule

`default_nettype wire

/* src/target_buffer.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bp_defines.svh"

////////////////////////////////////////////////////////////////////////////
// Direct mapped branch target buffer with tag check
////////////////////////////////////////////////////////////////////////////
module target_buffer
  import bp_pkg::*;
(
  input  logic                clk,                 // Core clock
  input  logic                reset,               // Sync, clears valid bits
  input  logic [`BP_PC_W-1:0] fetch_pc,            // PC being fetched
  input  bp_update_t          update,              // Resolved branch
  output logic                hit,                 // Valid entry, tag match
  output logic [`BP_PC_W-1:0] target               // Zero on a miss
);

  logic [`BP_INDEX_W-1:0] fetch_index;             // Entry for fetch PC
  logic [`BP_INDEX_W-1:0] upd_index;               // Entry for update PC
  logic [`BP_TAG_W-1:0]   fetch_tag;               // Upper fetch PC bits
  btb_entry_t             fetch_entry;             // Entry at fetch index
  btb_entry_t             new_entry;               // Install value
  logic                   install;                 // Taken branch write

  assign fetch_index = fetch_pc[`BP_INDEX_W-1:0];
  assign fetch_tag   = fetch_pc[`BP_PC_W-1:`BP_INDEX_W];
  assign upd_index   = update.pc[`BP_INDEX_W-1:0];

  // Not taken updates leave the entry alone
  assign new_entry = '{valid:  1'b1,
                       tag:    update.pc[`BP_PC_W-1:`BP_INDEX_W],
                       target: update.target};
  assign install   = update.valid && update.taken;

  entry_array #(
    .entry_t   (btb_entry_t)
  ) btb_array_inst (
    .clk       (clk),
    .reset     (reset),
    .rd_index  (fetch_index),
    .rd_entry  (fetch_entry),
    .upd_index (upd_index),
    .upd_entry (),
    .wr_en     (install),
    .wr_entry  (new_entry)
  );

  assign hit    = fetch_entry.valid && (fetch_entry.tag == fetch_tag);
  assign target = hit ? fetch_entry.target : '0;   // Aliased PCs give nothing

endmodule

`default_nettype wire

/* src/predict_stats_apb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bp_defines.svh"

////////////////////////////////////////////////////////////////////////////
// Prediction statistics on an APB slave port
////////////////////////////////////////////////////////////////////////////
module predict_stats_apb
  import bp_pkg::*;
(
  input  logic     clk,                            // Core clock
  input  logic     reset,                          // Sync, clears both counts
  input  apb_req_t apb_req,                        // APB request from master
  output apb_rsp_t apb_rsp,                        // Zero wait state response
  input  logic     update_seen,                    // A branch resolved
  input  logic     dir_wrong                       // Its direction was mispredicted
);

  logic [`BP_APB_DW-1:0] update_count;             // Wraps at 2^32
  logic [`BP_APB_DW-1:0] mispred_count;            // Wraps at 2^32
  logic [`BP_APB_DW-1:0] rd_data;                  // Decoded register value
  logic                  addr_ok;                  // Offset is mapped
  logic                  access;                   // Second APB phase
  logic                  clear;                    // Software clear request

  assign access = apb_req.psel && apb_req.penable;

  // Address decode
  always_comb begin
    addr_ok = 1'b1;
    rd_data = '0;
    case (apb_req.paddr)
      `BP_REG_UPDATES: rd_data = update_count;
      `BP_REG_MISPRED: rd_data = mispred_count;
      `BP_REG_CTRL:    rd_data = '0;               // Control reads back zero
      default:         addr_ok = 1'b0;             // Unmapped offset
    endcase
  end

  // Clear takes effect at the edge closing the access phase
  assign clear = access && apb_req.pwrite && addr_ok
                 && (apb_req.paddr == `BP_REG_CTRL) && apb_req.pwdata[0];

  always_ff @(posedge clk) begin
    if (reset) begin
      update_count  <= '0;
      mispred_count <= '0;
    end else if (clear) begin
      update_count  <= '0;                         // Clear wins over an update
      mispred_count <= '0;
    end else begin
      if (update_seen) begin
        update_count <= update_count + 1'b1;
      end
      if (dir_wrong) begin
        mispred_count <= mispred_count + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response, no wait states
  ////////////////////////////////////////////////////////////////////////////
  assign apb_rsp.prdata  = (apb_req.psel && !apb_req.pwrite && addr_ok)
                           ? rd_data : '0;
  assign apb_rsp.pready  = 1'b1;                   // Every transfer is two cycles
  assign apb_rsp.pslverr = access && !addr_ok;     // Only in the access phase

endmodule

`default_nettype wire

/* src/branch_predictor.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bp_defines.svh"

////////////////////////////////////////////////////////////////////////////
// Fetch stage branch predictor top level
////////////////////////////////////////////////////////////////////////////
module branch_predictor
  import bp_pkg::*;
(
  input  logic                clk,                 // Core clock
  input  logic                reset,               // Sync, active high
  input  logic [`BP_PC_W-1:0] fetch_pc,            // From the fetch stage
  output bp_predict_t         prediction,          // Same cycle as fetch_pc
  input  bp_update_t          update,              // From the resolving stage
  input  apb_req_t            apb_req,             // Statistics access
  output apb_rsp_t            apb_rsp
);

  logic                ctr_taken;                  // Counter says taken
  logic                btb_hit;                    // Target known for this PC
  logic [`BP_PC_W-1:0] btb_target;                 // Zero on a miss
  logic                dir_wrong;                  // Mispredicted direction

  counter_table counter_table_inst (
    .clk           (clk),
    .reset         (reset),
    .fetch_pc      (fetch_pc),
    .update        (update),
    .predict_taken (ctr_taken),
    .dir_wrong     (dir_wrong)
  );

  target_buffer target_buffer_inst (
    .clk      (clk),
    .reset    (reset),
    .fetch_pc (fetch_pc),
    .update   (update),
    .hit      (btb_hit),
    .target   (btb_target)
  );

  predict_stats_apb predict_stats_apb_inst (
    .clk         (clk),
    .reset       (reset),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .update_seen (update.valid),                   // Every resolved branch counts
    .dir_wrong   (dir_wrong)
  );

  // Redirect only when a target is known
  assign prediction = '{taken:  ctr_taken && btb_hit,
                        hit:    btb_hit,
                        target: btb_target};

endmodule

`default_nettype wire

/* tb/bp_checker.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bp_defines.svh"

////////////////////////////////////////////////////////////////////////////
// Reference model of both tables and the statistics counters
////////////////////////////////////////////////////////////////////////////
module bp_checker
  import bp_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic [`BP_PC_W-1:0] fetch_pc,
  input  bp_predict_t         prediction,
  input  bp_update_t          update,
  input  apb_req_t            apb_req,
  input  apb_rsp_t            apb_rsp,
  output int                  check_count,
  output int                  error_count
);

  bp_ctr_t                model_ctr [`BP_DEPTH];         // Direction counters
  btb_entry_t             model_btb [`BP_DEPTH];         // Target entries
  logic [31:0]            model_updates;                 // Wraps like the DUT
  logic [31:0]            model_mispred;
  logic [`BP_INDEX_W-1:0] upd_idx;
  logic [`BP_INDEX_W-1:0] f_idx;
  logic                   exp_hit;
  logic                   mapped;
  logic                   clear_req;

  initial begin
    check_count = 0;
    error_count = 0;
  end

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("ERROR %0t %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  function automatic logic [31:0] register_value(input logic [7:0] addr);
    if (addr == `BP_REG_UPDATES) return model_updates;
    if (addr == `BP_REG_MISPRED) return model_mispred;
    return 32'h0;                                        // Control and unmapped
  endfunction

  // Model state moves at each edge
  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `BP_DEPTH; i++) begin
        model_ctr[i] = 2'd0;                             // Strong not taken
        model_btb[i] = '0;
      end
      model_updates = 32'h0;
      model_mispred = 32'h0;
    end else begin
      upd_idx   = update.pc[`BP_INDEX_W-1:0];
      clear_req = apb_req.psel && apb_req.penable && apb_req.pwrite
                  && (apb_req.paddr == `BP_REG_CTRL) && apb_req.pwdata[0];
      if (clear_req) begin
        model_updates = 32'h0;                           // Clear beats same edge update
        model_mispred = 32'h0;
      end else if (update.valid) begin
        model_updates = model_updates + 32'h1;
        if (update.taken != model_ctr[upd_idx][1])
          model_mispred = model_mispred + 32'h1;
      end
      if (update.valid) begin
        if (update.taken && model_ctr[upd_idx] != 2'd3)
          model_ctr[upd_idx] = model_ctr[upd_idx] + 2'd1;
        else if (!update.taken && model_ctr[upd_idx] != 2'd0)
          model_ctr[upd_idx] = model_ctr[upd_idx] - 2'd1;
        if (update.taken)
          model_btb[upd_idx] = '{valid: 1'b1, tag: update.pc[15:4], target: update.target};
      end
    end
  end

  // Compare mid cycle, long after inputs settle
  always @(negedge clk) begin
    if (!reset) begin
      f_idx   = fetch_pc[`BP_INDEX_W-1:0];
      exp_hit = model_btb[f_idx].valid && (model_btb[f_idx].tag == fetch_pc[15:4]);
      compare_value("prediction.hit", exp_hit, prediction.hit);
      compare_value("prediction.taken", exp_hit && model_ctr[f_idx][1], prediction.taken);
      compare_value("prediction.target", exp_hit ? model_btb[f_idx].target : 16'h0,
                    prediction.target);
      if (apb_req.psel && apb_req.penable) begin
        mapped = (apb_req.paddr == `BP_REG_UPDATES) || (apb_req.paddr == `BP_REG_MISPRED)
                 || (apb_req.paddr == `BP_REG_CTRL);
        compare_value("apb_rsp.pready", 1'b1, apb_rsp.pready);
        compare_value("apb_rsp.pslverr", !mapped, apb_rsp.pslverr);
        if (!apb_req.pwrite)
          compare_value("apb_rsp.prdata", register_value(apb_req.paddr), apb_rsp.prdata);
      end else begin
        compare_value("apb_rsp.pslverr", 1'b0, apb_rsp.pslverr);  // Idle or setup
      end
    end
  end

endmodule

`default_nettype wire

/* tb/tb_branch_predictor.sv */
`timescale 1ns/10ps
`default_nettype none
`include "bp_defines.svh"

module tb_branch_predictor
  import bp_pkg::*;
;

  localparam int                  TIMEOUT = 20;            // Cycles allowed for pready
  localparam logic [`BP_PC_W-1:0] PC_A    = 16'h1003;      // Index 3, tag 0x100
  localparam logic [`BP_PC_W-1:0] PC_B    = 16'h2003;      // Index 3, tag 0x200
  localparam logic [`BP_PC_W-1:0] PC_C    = 16'h1005;      // Index 5 stays strong not taken
  localparam logic [`BP_PC_W-1:0] TGT_A   = 16'h0a40;
  localparam logic [`BP_PC_W-1:0] TGT_B   = 16'h0b80;

  logic                clk;
  logic                reset;
  logic [`BP_PC_W-1:0] fetch_pc;
  bp_predict_t         prediction;
  bp_update_t          update;
  apb_req_t            apb_req;
  apb_rsp_t            apb_rsp;
  logic                traffic_on;                         // Random fetch and update
  logic [`BP_PC_W-1:0] pc_pool [6];                        // Revisited PCs with some aliasing
  logic [31:0]         rdata;
  logic                rerr;
  int                  tb_errors;
  int                  tb_checks;
  int                  check_count;
  int                  error_count;
  int unsigned         seed_value;

  branch_predictor branch_predictor_inst (
    .clk        (clk),
    .reset      (reset),
    .fetch_pc   (fetch_pc),
    .prediction (prediction),
    .update     (update),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp)
  );

  bp_checker checker_inst (
    .clk         (clk),
    .reset       (reset),
    .fetch_pc    (fetch_pc),
    .prediction  (prediction),
    .update      (update),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .check_count (check_count),
    .error_count (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;                                // 40 ns period
  end

  // Random traffic that sometimes fetches the index being updated
  always @(posedge clk) begin
    if (traffic_on) begin
      #2;
      update.valid  = ($urandom % 4) != 0;
      update.pc     = pc_pool[$urandom % 6];
      update.taken  = $urandom % 2;
      update.target = $urandom;
      fetch_pc      = (($urandom % 4) == 0) ? update.pc : pc_pool[$urandom % 6];
    end
  end

  task automatic expect_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    tb_checks++;
    if (exp !== act) begin
      tb_errors++;
      $display("ERROR %0t %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  task automatic drive_step(input logic [15:0] pc, input logic uvalid, input logic [15:0] upc,
                            input logic utaken, input logic [15:0] utarget);
    @(posedge clk);
    #2;
    fetch_pc = pc;
    update   = '{valid: uvalid, pc: upc, taken: utaken, target: utarget};
  endtask

  task automatic fetch_and_expect(input logic [15:0] pc, input logic exp_hit,
                                  input logic exp_taken, input logic [15:0] exp_target);
    drive_step(pc, 1'b0, 16'h0, 1'b0, 16'h0);
    @(negedge clk);                                        // Stable mid cycle
    expect_value("prediction.hit", exp_hit, prediction.hit);
    expect_value("prediction.taken", exp_taken, prediction.taken);
    expect_value("prediction.target", exp_target, prediction.target);
  endtask

  task automatic apb_transfer(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata);
    int wait_cnt;
    wait_cnt = 0;
    @(posedge clk);
    #2;
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge clk);
    #2;
    apb_req.penable = 1'b1;                                // Access phase
    @(negedge clk);
    while (!apb_rsp.pready && wait_cnt < TIMEOUT) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (!apb_rsp.pready) begin
      tb_errors++;
      $display("APB transfer to offset %0h got no pready within %0d cycles", addr, TIMEOUT);
    end
    rdata = apb_rsp.prdata;
    rerr  = apb_rsp.pslverr;
    @(posedge clk);
    #2;
    apb_req = '0;
  endtask

  initial begin
    reset      = 1'b1;
    traffic_on = 1'b0;
    fetch_pc   = '0;
    update     = '0;
    apb_req    = '0;
    tb_errors  = 0;
    tb_checks  = 0;
    seed_value = $urandom(32'h5b6e);                        // One seed for the run
    pc_pool    = '{16'h1003, 16'h2003, 16'h1007, 16'h3007, 16'h100a, 16'h400f};
    repeat (4) @(posedge clk);
    #2 reset = 1'b0;

    // Cleared tables give no prediction anywhere
    for (int i = 0; i < `BP_DEPTH; i++) begin
      fetch_and_expect({12'h123, i[3:0]}, 1'b0, 1'b0, 16'h0);
    end
    apb_transfer(1'b0, `BP_REG_UPDATES, 32'h0);
    expect_value("update count", 32'h0, rdata);
    apb_transfer(1'b0, `BP_REG_MISPRED, 32'h0);
    expect_value("mispredict count", 32'h0, rdata);

    // Counter steps 0 to 2 and then saturates at 3
    drive_step(PC_A, 1'b1, PC_A, 1'b1, TGT_A);
    drive_step(PC_A, 1'b1, PC_A, 1'b1, TGT_A);
    fetch_and_expect(PC_A, 1'b1, 1'b1, TGT_A);
    repeat (3) drive_step(PC_A, 1'b1, PC_A, 1'b1, TGT_A);
    fetch_and_expect(PC_A, 1'b1, 1'b1, TGT_A);
    drive_step(PC_A, 1'b1, PC_A, 1'b0, 16'h0);             // 3 to 2
    fetch_and_expect(PC_A, 1'b1, 1'b1, TGT_A);
    drive_step(PC_A, 1'b1, PC_A, 1'b0, 16'h0);             // 2 to 1 with the BTB entry kept
    fetch_and_expect(PC_A, 1'b1, 1'b0, TGT_A);

    // Tag conflict at index 3
    fetch_and_expect(PC_B, 1'b0, 1'b0, 16'h0);
    drive_step(PC_B, 1'b1, PC_B, 1'b1, TGT_B);             // Replaces the PC_A entry
    fetch_and_expect(PC_B, 1'b1, 1'b1, TGT_B);
    fetch_and_expect(PC_A, 1'b0, 1'b0, 16'h0);
    apb_transfer(1'b0, `BP_REG_UPDATES, 32'h0);
    expect_value("update count", 32'd8, rdata);
    apb_transfer(1'b0, `BP_REG_MISPRED, 32'h0);
    expect_value("mispredict count", 32'd5, rdata);

    ////////////////////////////////////////////////////////////////////////////
    // Long random traffic with interleaved APB reads and clears
    ////////////////////////////////////////////////////////////////////////////
    traffic_on = 1'b1;
    for (int n = 0; n < 24; n++) begin
      repeat (5 + $urandom % 25) @(posedge clk);
      if (($urandom % 6) == 0) begin
        apb_transfer(1'b1, `BP_REG_CTRL, 32'h1);
      end else begin
        apb_transfer(1'b0, (($urandom % 2) == 0) ? `BP_REG_UPDATES : `BP_REG_MISPRED, 32'h0);
      end
    end
    traffic_on = 1'b0;

    // Clear and a mispredicted update meet at one edge
    fork
      apb_transfer(1'b1, `BP_REG_CTRL, 32'h1);
      begin
        @(posedge clk);
        @(posedge clk);
        #2 update = '{valid: 1'b1, pc: PC_C, taken: 1'b1, target: TGT_A};
        @(posedge clk);
        #2 update = '0;
      end
    join
    apb_transfer(1'b0, `BP_REG_UPDATES, 32'h0);
    expect_value("update count after clear", 32'h0, rdata);
    apb_transfer(1'b0, `BP_REG_MISPRED, 32'h0);
    expect_value("mispredict count after clear", 32'h0, rdata);

    // Unmapped offset and the control register
    apb_transfer(1'b0, 8'h0c, 32'h0);
    expect_value("apb_rsp.pslverr", 1'b1, rerr);
    expect_value("apb_rsp.prdata", 32'h0, rdata);
    apb_transfer(1'b0, `BP_REG_CTRL, 32'h0);
    expect_value("apb_rsp.pslverr", 1'b0, rerr);
    expect_value("apb_rsp.prdata", 32'h0, rdata);

    repeat (2) @(posedge clk);
    $display("checks %0d errors %0d", check_count + tb_checks, error_count + tb_errors);
    if (error_count + tb_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
src/bp_pkg.sv
src/entry_array.sv
src/counter_table.sv
src/target_buffer.sv
src/predict_stats_apb.sv
src/branch_predictor.sv
tb/bp_checker.sv
tb/tb_branch_predictor.sv
